// File: verilog/cpu_mem_pkg.sv
package cpu_mem_pkg;

    localparam int    DATA_W        = 32;              // Data and address bus width
    localparam int    MEM_WORDS     = 16;              // Memory depth in words
    localparam int    MEM_LATENCY   = 3;               // Busy cycles per request
    localparam string MEM_INIT_FILE = "mem_init.hex";  // Program and load data image

    // Handler sequence for one instruction slot
    typedef enum logic [1:0] {
        FETCH  = 2'd0,  // Request the instruction word
        F_WAIT = 2'd1,  // Wait for the fetch to finish
        DATA   = 2'd2,  // Decide on load, store or nothing
        D_WAIT = 2'd3   // Wait for the data access
    } state_t;

    // Memory operation codes from the control unit
    typedef enum logic [3:0] {
        MOP_NONE = 4'd0,
        MOP_LB   = 4'd1,  // Load byte, sign extended
        MOP_LH   = 4'd2,  // Load halfword, sign extended
        MOP_LW   = 4'd3,  // Load word
        MOP_LBU  = 4'd4,  // Load byte, zero extended
        MOP_LHU  = 4'd5,  // Load halfword, zero extended
        MOP_SB   = 4'd6,  // Store byte
        MOP_SH   = 4'd7,  // Store halfword
        MOP_SW   = 4'd8   // Store word
    } mem_op_t;

    // Request type seen by the memory
    typedef enum logic [1:0] {
        RWI_IDLE  = 2'b00,
        RWI_STORE = 2'b01,
        RWI_LOAD  = 2'b10,
        RWI_FETCH = 2'b11
    } rwi_t;

endpackage

// File: verilog/cpu_memory_handler.sv
module cpu_memory_handler (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           busy,          // Memory busy level
    input  cpu_mem_pkg::mem_op_t           mem_op,        // Load/store type
    input  logic                           mem_write,     // Store request in DATA
    input  logic                           mem_read,      // Load request in DATA
    input  logic                           mem_source,    // 1 stores FPU data, 0 register data
    input  logic [cpu_mem_pkg::DATA_W-1:0] alu_address,   // Data address from the ALU
    input  logic [cpu_mem_pkg::DATA_W-1:0] fpu_data,
    input  logic [cpu_mem_pkg::DATA_W-1:0] reg_data,
    input  logic [cpu_mem_pkg::DATA_W-1:0] ext_data,      // Word returned by the memory
    output logic [cpu_mem_pkg::DATA_W-1:0] write_data,    // Formatted store word
    output logic [cpu_mem_pkg::DATA_W-1:0] data_address,  // Latched load/store address
    output logic [cpu_mem_pkg::DATA_W-1:0] data_to_reg,   // Extended load result
    output logic                           freeze,        // Stalls the rest of the CPU
    output logic                           reg_write,     // Load result strobe
    output logic                           instr_valid,   // Fetched word present on ext_data
    output logic                           addr_control,  // 1 selects pc, 0 the data address
    output cpu_mem_pkg::rwi_t              rwi,
    output cpu_mem_pkg::state_t            state
);
    import cpu_mem_pkg::*;

    state_t                state_n;
    logic                  prev_busy;   // Busy from the previous cycle
    logic                  busy_edge;   // Memory just finished
    rwi_t                  req_q;       // Data request held through D_WAIT
    mem_op_t               op_q;        // Load type kept for the result
    logic                  load_done;   // Last cycle of a load
    logic [DATA_W-1:0]     src_data;
    logic [DATA_W-1:0]     store_data;
    logic [DATA_W-1:0]     load_data;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            prev_busy <= 1'b0;
        end else begin
            prev_busy <= busy;
        end
    end

    assign busy_edge = ~busy & prev_busy;  // Falling edge of busy

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= FETCH;
            req_q <= RWI_IDLE;
        end else begin
            state <= state_n;
            if (state == DATA) begin
                req_q <= rwi;  // Keep driving the same request while waiting
            end
        end
    end

    always_comb begin
        state_n      = state;
        rwi          = RWI_IDLE;
        freeze       = 1'b1;  // Frozen everywhere except FETCH
        addr_control = 1'b0;
        case (state)
            FETCH: begin
                rwi          = RWI_FETCH;
                freeze       = 1'b0;
                addr_control = 1'b1;
                state_n      = F_WAIT;
            end
            F_WAIT: begin
                rwi          = RWI_FETCH;
                addr_control = 1'b1;
                if (busy_edge) begin
                    state_n = DATA;
                end
            end
            DATA: begin
                if (mem_write) begin
                    rwi     = RWI_STORE;
                    state_n = D_WAIT;
                end else if (mem_read) begin
                    rwi     = RWI_LOAD;
                    state_n = D_WAIT;
                end else begin
                    state_n = FETCH;  // No data access in this slot
                end
            end
            D_WAIT: begin
                rwi = req_q;
                if (busy_edge) begin
                    state_n = FETCH;
                end
            end
            default: state_n = FETCH;
        endcase
    end

    assign instr_valid = (state == F_WAIT) & busy_edge;
    assign load_done   = (state == D_WAIT) & busy_edge & (req_q == RWI_LOAD);

    assign src_data = mem_source ? fpu_data : reg_data;

    // Store data is zero extended, the memory writes whole words
    always_comb begin
        case (mem_op)
            MOP_SB:  store_data = {24'b0, src_data[7:0]};
            MOP_SH:  store_data = {16'b0, src_data[15:0]};
            MOP_SW:  store_data = src_data;
            default: store_data = '0;  // Invalid store op
        endcase
    end

    always_comb begin
        case (op_q)
            MOP_LB:  load_data = {{24{ext_data[7]}}, ext_data[7:0]};
            MOP_LH:  load_data = {{16{ext_data[15]}}, ext_data[15:0]};
            MOP_LW:  load_data = ext_data;
            MOP_LBU: load_data = {24'b0, ext_data[7:0]};
            MOP_LHU: load_data = {16'b0, ext_data[15:0]};
            default: load_data = '0;  // Invalid load op
        endcase
    end

    // Address and store word stay put while the memory is busy
    always_ff @(posedge clk) begin
        if (state == DATA) begin
            data_address <= alu_address;
            op_q         <= mem_op;
            if (mem_write) begin
                write_data <= store_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            reg_write   <= 1'b0;
            data_to_reg <= '0;
        end else begin
            reg_write <= load_done;  // One cycle after busy falls
            if (load_done) begin
                data_to_reg <= load_data;
            end
        end
    end

    // CPU runs only while the memory is free for the next fetch
    a_freeze_fetch: assert property (@(posedge clk) disable iff (!nrst)
        !freeze |-> !busy)
        else $error("freeze low while the memory is busy");

    // No load strobe anywhere in the window of a store access
    a_no_store_write: assert property (@(posedge clk) disable iff (!nrst)
        (state == DATA && mem_write) |=> !reg_write [*MEM_LATENCY + 3])
        else $error("reg_write after a store request");

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           instr_valid,   // Fetched word on ext_data
    input  logic                           addr_control,  // 1 selects pc
    input  logic [cpu_mem_pkg::DATA_W-1:0] ext_data,      // Word from memory
    input  logic [cpu_mem_pkg::DATA_W-1:0] data_address,  // Load/store address from handler
    output logic [cpu_mem_pkg::DATA_W-1:0] pc,
    output logic [cpu_mem_pkg::DATA_W-1:0] instr,         // Last fetched instruction
    output logic [cpu_mem_pkg::DATA_W-1:0] ext_address    // Address to memory
);
    import cpu_mem_pkg::*;

    logic              advance;  // instr_valid one cycle late
    logic [DATA_W-1:0] pc_next;

    // Wrap inside the memory so every word gets fetched in turn
    assign pc_next = (pc + 32'd4) & DATA_W'(MEM_WORDS * 4 - 1);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc      <= '0;
            advance <= 1'b0;
        end else begin
            advance <= instr_valid;
            if (advance) begin
                pc <= pc_next;  // Step after the instruction is held
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr <= ext_data;  // Capture on the busy falling edge cycle
        end
    end

    // Fetch states use pc, data states the latched address
    assign ext_address = addr_control ? pc : data_address;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!nrst)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// File: verilog/ext_memory.sv
module ext_memory (
    input  logic                           clk,
    input  logic                           nrst,
    input  cpu_mem_pkg::rwi_t              rwi,          // Request level from handler
    input  logic [cpu_mem_pkg::DATA_W-1:0] ext_address,
    input  logic [cpu_mem_pkg::DATA_W-1:0] write_data,
    output logic                           busy,         // High while an access runs
    output logic [cpu_mem_pkg::DATA_W-1:0] ext_data      // Result of last fetch or load
);
    import cpu_mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'd0,  // Waiting for a request
        BUSY = 2'd1,  // Access in progress
        DONE = 2'd2   // Ignores the lingering request
    } mem_state_t;

    typedef logic [$clog2(MEM_LATENCY + 1)-1:0] lat_cnt_t;

    mem_state_t                     mstate;
    lat_cnt_t                       cnt;       // Busy cycles left minus one
    logic                           pending;   // Request seen on the last edge
    logic                           start;
    logic                           finish;
    rwi_t                           req_rwi;
    logic [$clog2(MEM_WORDS)-1:0]   req_word;  // Word index of the access
    logic [DATA_W-1:0]              req_data;
    logic [DATA_W-1:0]              mem [0:MEM_WORDS-1];

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    // Request is taken on its second edge, once address and data are settled
    assign start  = (mstate == IDLE) & pending & (rwi != RWI_IDLE);
    assign finish = (mstate == BUSY) & (cnt == '0);
    assign busy   = (mstate == BUSY);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            mstate  <= IDLE;
            cnt     <= '0;
            pending <= 1'b0;
        end else begin
            case (mstate)
                IDLE: begin
                    if (start) begin
                        mstate  <= BUSY;
                        cnt     <= lat_cnt_t'(MEM_LATENCY - 1);
                        pending <= 1'b0;
                    end else begin
                        pending <= (rwi != RWI_IDLE);
                    end
                end
                BUSY: begin
                    if (cnt == '0) begin
                        mstate <= DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                DONE:    mstate <= IDLE;  // One dead cycle after busy falls
                default: mstate <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_rwi  <= rwi;
            req_word <= ext_address[$clog2(MEM_WORDS)+1:2];
            req_data <= write_data;
        end
        if (finish) begin
            if (req_rwi == RWI_STORE) begin
                mem[req_word] <= req_data;  // Full word write
            end else begin
                ext_data <= mem[req_word];  // Fetch or load, held until next read
            end
        end
    end

    a_busy_len: assert property (@(posedge clk) disable iff (!nrst)
        $rose(busy) |-> ##MEM_LATENCY !busy)
        else $error("busy held longer than %0d cycles", MEM_LATENCY);

endmodule

// File: verilog/cpu_mem_top.sv
module cpu_mem_top (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           mem_write,    // Store in this slot
    input  logic                           mem_read,     // Load in this slot
    input  logic                           mem_source,   // 1 stores FPU data
    input  cpu_mem_pkg::mem_op_t           mem_op,
    input  logic [cpu_mem_pkg::DATA_W-1:0] alu_address,
    input  logic [cpu_mem_pkg::DATA_W-1:0] fpu_data,
    input  logic [cpu_mem_pkg::DATA_W-1:0] reg_data,
    output logic [cpu_mem_pkg::DATA_W-1:0] data_to_reg,
    output logic [cpu_mem_pkg::DATA_W-1:0] pc,
    output logic [cpu_mem_pkg::DATA_W-1:0] instr,
    output logic                           reg_write,
    output logic                           instr_valid,
    output logic                           freeze,
    output cpu_mem_pkg::rwi_t              rwi,
    output cpu_mem_pkg::state_t            state
);
    import cpu_mem_pkg::*;

    logic              busy;          // Memory busy level
    logic              addr_control;  // Address mux select
    logic [DATA_W-1:0] ext_data;      // Memory read word
    logic [DATA_W-1:0] ext_address;   // Muxed memory address
    logic [DATA_W-1:0] write_data;    // Store word to memory
    logic [DATA_W-1:0] data_address;  // Latched data address

    cpu_memory_handler u_handler (
        .clk          (clk),
        .nrst         (nrst),
        .busy         (busy),
        .mem_op       (mem_op),
        .mem_write    (mem_write),
        .mem_read     (mem_read),
        .mem_source   (mem_source),
        .alu_address  (alu_address),
        .fpu_data     (fpu_data),
        .reg_data     (reg_data),
        .ext_data     (ext_data),
        .write_data   (write_data),
        .data_address (data_address),
        .data_to_reg  (data_to_reg),
        .freeze       (freeze),
        .reg_write    (reg_write),
        .instr_valid  (instr_valid),
        .addr_control (addr_control),
        .rwi          (rwi),
        .state        (state)
    );

    fetch_unit u_fetch (
        .clk          (clk),
        .nrst         (nrst),
        .instr_valid  (instr_valid),
        .addr_control (addr_control),
        .ext_data     (ext_data),
        .data_address (data_address),
        .pc           (pc),
        .instr        (instr),
        .ext_address  (ext_address)
    );

    ext_memory u_memory (
        .clk         (clk),
        .nrst        (nrst),
        .rwi         (rwi),
        .ext_address (ext_address),
        .write_data  (write_data),
        .busy        (busy),
        .ext_data    (ext_data)
    );

endmodule

// File: tests/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk  = 1'b0;
        nrst = 1'b0;             // Reset over the first two rising edges
        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;             // Released on a falling edge
    end

    always #20 clk = ~clk;       // Period 40

endmodule

// File: tests/tb_cpu_mem.sv
module tb_cpu_mem;
    import cpu_mem_pkg::*;

    localparam int          SLOTS          = 48;
    localparam int          TIMEOUT_CYCLES = SLOTS * (2 * MEM_LATENCY + 8);
    localparam logic [31:0] LFSR_POLY      = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

    typedef enum logic [1:0] {
        SLOT_NONE,
        SLOT_STORE,
        SLOT_LOAD
    } slot_kind_t;

    logic              clk;
    logic              nrst;
    logic              mem_write;
    logic              mem_read;
    logic              mem_source;
    mem_op_t           mem_op;
    logic [DATA_W-1:0] alu_address;
    logic [DATA_W-1:0] fpu_data;
    logic [DATA_W-1:0] reg_data;
    logic [DATA_W-1:0] data_to_reg;
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] instr;
    logic              reg_write;
    logic              instr_valid;
    logic              freeze;
    rwi_t              rwi;
    state_t            state;

    logic [DATA_W-1:0] model [0:MEM_WORDS-1];  // Reference copy of the memory
    logic [31:0]       lfsr_state;
    logic [DATA_W-1:0] slot_pc;                // Address of the next fetch
    logic [DATA_W-1:0] exp_pc;
    logic [DATA_W-1:0] exp_pc_next;
    logic [DATA_W-1:0] exp_instr;
    logic [DATA_W-1:0] exp_load;
    rwi_t              exp_rwi;                // Request expected in DATA
    slot_kind_t        slot_kind;
    logic [3:0]        last_store;             // Word of the latest store
    int                loads_issued;
    int                loads_seen;
    int                cycle_count;

    clock_gen u_clock (
        .clk  (clk),
        .nrst (nrst)
    );

    cpu_mem_top UUT (
        .clk         (clk),
        .nrst        (nrst),
        .mem_write   (mem_write),
        .mem_read    (mem_read),
        .mem_source  (mem_source),
        .mem_op      (mem_op),
        .alu_address (alu_address),
        .fpu_data    (fpu_data),
        .reg_data    (reg_data),
        .data_to_reg (data_to_reg),
        .pc          (pc),
        .instr       (instr),
        .reg_write   (reg_write),
        .instr_valid (instr_valid),
        .freeze      (freeze),
        .rwi         (rwi),
        .state       (state)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Galois LFSR, one step per bit, first bit lands in the MSB
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        out_bit;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ LFSR_POLY;
            end
            bits = {bits[30:0], out_bit};
        end
        return bits;
    endfunction

    // Word left in memory by a store, zero extended
    function automatic logic [31:0] stored_word(input mem_op_t op, input logic [31:0] src);
        case (op)
            MOP_SB:  return src & 32'h0000_00ff;
            MOP_SH:  return src & 32'h0000_ffff;
            MOP_SW:  return src;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] loaded_value(input mem_op_t op, input logic [31:0] w);
        case (op)
            MOP_LB:  return 32'($signed(w[7:0]));   // Sign bit 7
            MOP_LH:  return 32'($signed(w[15:0]));  // Sign bit 15
            MOP_LW:  return w;
            MOP_LBU: return 32'(w[7:0]);
            MOP_LHU: return 32'(w[15:0]);
            default: return 32'h0;
        endcase
    endfunction

    // Acts as the control unit for one slot, called in the instr_valid cycle
    task automatic run_slot(input int idx);
        int          pos;
        logic [31:0] rnd;
        logic [3:0]  word;
        logic        src_fpu;
        mem_op_t     op;
        slot_kind_t  kind;
        pos         = idx % 24;
        exp_pc      = slot_pc;
        exp_pc_next = (slot_pc + 32'd4) & 32'd63;  // Wraps after word 15
        exp_instr   = model[slot_pc[5:2]];
        slot_pc     = exp_pc_next;
        reg_data    = take_bits(32);
        fpu_data    = take_bits(32);
        src_fpu     = 1'b0;
        word        = 4'd0;
        if (pos < 12 && pos % 2 == 0) begin
            kind    = SLOT_STORE;  // SB, SH, SW from each source
            op      = (pos < 4) ? MOP_SB : (pos < 8) ? MOP_SH : MOP_SW;
            src_fpu = (pos % 4 == 2);
        end else if (pos < 12 || pos == 18) begin
            kind = SLOT_LOAD;
            op   = MOP_LW;         // Read back the stored word
        end else begin
            rnd = take_bits(2);
            case (pos)
                12, 20:  op = MOP_LB;
                13, 23:  op = MOP_LH;
                14, 22:  op = MOP_LBU;
                15:      op = MOP_LHU;
                default: op = mem_op_t'(4'd9 + {2'b0, rnd[1:0]});  // Undefined codes
            endcase
            kind = (pos == 16 || pos == 21) ? SLOT_NONE :
                   (pos == 17) ? SLOT_STORE : SLOT_LOAD;
            if (kind == SLOT_NONE) begin
                op = MOP_NONE;
            end
        end
        if (kind == SLOT_STORE) begin
            rnd        = take_bits(3);
            word       = {1'b1, rnd[2:0]};  // Words 8 to 15 only
            last_store = word;
            model[word] = stored_word(op, src_fpu ? fpu_data : reg_data);
        end else if (kind == SLOT_LOAD) begin
            rnd  = take_bits(4);
            word = (op == MOP_LW) ? last_store : rnd[3:0];
            exp_load = loaded_value(op, model[word]);
            loads_issued++;
        end
        exp_rwi     = (kind == SLOT_STORE) ? RWI_STORE :
                      (kind == SLOT_LOAD) ? RWI_LOAD : RWI_IDLE;
        slot_kind   = kind;
        mem_write   = (kind == SLOT_STORE);
        mem_read    = (kind == SLOT_LOAD);
        mem_source  = src_fpu;
        mem_op      = op;
        alu_address = {26'b0, word, 2'b00};
    endtask

    a_reset_ctrl: assert property (@(posedge clk) $rose(nrst) |->
        state == FETCH && !freeze && rwi == RWI_FETCH && !UUT.busy)
        else report_failure($sformatf("Mismatch after reset: state %h freeze %h rwi %h busy %h",
            $sampled(state), $sampled(freeze), $sampled(rwi), $sampled(UUT.busy)));

    a_reset_data: assert property (@(posedge clk) $rose(nrst) |->
        pc == '0 && data_to_reg == '0 && !reg_write && !instr_valid)
        else report_failure($sformatf("Mismatch after reset: pc %h data_to_reg %h reg_write %h",
            $sampled(pc), $sampled(data_to_reg), $sampled(reg_write)));

    a_freeze_high: assert property (@(posedge clk) disable iff (!nrst)
        state != FETCH |-> freeze)
        else report_failure($sformatf("Mismatch freeze: got %h expected 1 in state %h",
            $sampled(freeze), $sampled(state)));

    a_fetch_pc: assert property (@(posedge clk) disable iff (!nrst)
        instr_valid |-> pc == exp_pc)
        else report_failure($sformatf("Mismatch pc: got %h expected %h", $sampled(pc), exp_pc));

    a_fetch_instr: assert property (@(posedge clk) disable iff (!nrst)
        $past(instr_valid) |-> instr == exp_instr)
        else report_failure($sformatf("Mismatch instr: got %h expected %h",
            $sampled(instr), exp_instr));

    a_pc_step: assert property (@(posedge clk) disable iff (!nrst)
        $past(instr_valid, 2) |-> pc == exp_pc_next)
        else report_failure($sformatf("Mismatch pc: got %h expected %h after a fetch",
            $sampled(pc), exp_pc_next));

    a_data_rwi: assert property (@(posedge clk) disable iff (!nrst)
        state == DATA |-> rwi == exp_rwi)
        else report_failure($sformatf("Mismatch rwi: got %h expected %h in DATA",
            $sampled(rwi), exp_rwi));

    a_noop_return: assert property (@(posedge clk) disable iff (!nrst)
        $past(state == DATA && slot_kind == SLOT_NONE) |-> state == FETCH)
        else report_failure($sformatf("Mismatch state: got %h expected %h after a no-op DATA",
            $sampled(state), FETCH));

    a_load_strobe: assert property (@(posedge clk) disable iff (!nrst)
        $past(state == D_WAIT && slot_kind == SLOT_LOAD) && state == FETCH |-> reg_write)
        else report_failure("Load finished but reg_write did not pulse");

    a_load_only: assert property (@(posedge clk) disable iff (!nrst)
        reg_write |-> slot_kind == SLOT_LOAD)
        else report_failure($sformatf("Mismatch reg_write: got %h expected 0 without a load",
            $sampled(reg_write)));

    a_load_value: assert property (@(posedge clk) disable iff (!nrst)
        reg_write |-> data_to_reg == exp_load)
        else report_failure($sformatf("Mismatch data_to_reg: got %h expected %h",
            $sampled(data_to_reg), exp_load));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (nrst && reg_write) begin
            loads_seen <= loads_seen + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles before all slots ran", cycle_count));
        end
    end

    initial begin
        mem_write    = 1'b0;
        mem_read     = 1'b0;
        mem_source   = 1'b0;
        mem_op       = MOP_NONE;
        alu_address  = '0;
        fpu_data     = '0;
        reg_data     = '0;
        lfsr_state   = 32'd97199;
        slot_pc      = '0;
        exp_pc       = '0;
        exp_pc_next  = '0;
        exp_instr    = '0;
        exp_load     = '0;
        exp_rwi      = RWI_IDLE;
        slot_kind    = SLOT_NONE;
        last_store   = 4'd8;
        loads_issued = 0;
        loads_seen   = 0;
        cycle_count  = 0;
        $readmemh(MEM_INIT_FILE, model);
        @(posedge nrst);
        for (int slot = 0; slot < SLOTS; slot++) begin
            @(negedge clk);
            while (!instr_valid) begin
                @(negedge clk);
            end
            run_slot(slot);
        end
        @(negedge clk);
        while (state != FETCH) begin
            @(negedge clk);  // Let the last data access finish
        end
        repeat (2) @(negedge clk);
        if (loads_seen != loads_issued) begin
            report_failure($sformatf("Mismatch load count: got %h expected %h",
                loads_seen, loads_issued));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: list.f
verilog/cpu_mem_pkg.sv
verilog/cpu_memory_handler.sv
verilog/fetch_unit.sv
verilog/ext_memory.sv
verilog/cpu_mem_top.sv
tests/clock_gen.sv
tests/tb_cpu_mem.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, then run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_mem \
    -f list.f \
    --Mdir obj_dir -o sim_tb_cpu_mem
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb_cpu_mem
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

// File: mem_init.hex
// One 32-bit word per line in hex, word addresses 0 to 15
00000013
8badf00d
12345678
fedcba98
0000ff80
7fff8000
a5a55a5a
00000001
deadbeef
cafe7f7f
80000080
13579bdf
ffffffff
0f0f00f0
69c3e4a1
2468ace0
